// File: verilog/qa_pkg.sv
/* QA accelerator package
   Shared widths, host CSR byte addresses, the DSM marker and the FSM state types */

package qa_pkg;

    // Bus addresses and the base registers count 32-bit words, not bytes
    localparam int ADDR_W     = 64;
    localparam int DATA_W     = 32;

    // Host writes carry a word address, so the byte form adds two zero bits
    localparam int CFG_ADDR_W = 12;

    // The word count also fills the low half of DSM word 0
    localparam int COUNT_W    = 16;

    // CSR byte addresses
    // Each one is the host word address followed by two zero bits
    localparam logic [13:0] CSR_AFU_DSM_BASEL         = {12'h680, 2'b00};
    localparam logic [13:0] CSR_AFU_DSM_BASEH         = {12'h681, 2'b00};
    localparam logic [13:0] CSR_AFU_READ_FRAME_BASEL  = {12'h684, 2'b00};
    localparam logic [13:0] CSR_AFU_READ_FRAME_BASEH  = {12'h685, 2'b00};
    localparam logic [13:0] CSR_AFU_WRITE_FRAME_BASEL = {12'h686, 2'b00};
    localparam logic [13:0] CSR_AFU_WRITE_FRAME_BASEH = {12'h687, 2'b00};
    localparam logic [13:0] CSR_AFU_NUM_WORDS         = {12'h688, 2'b00};
    localparam logic [13:0] CSR_AFU_EN                = {12'h689, 2'b00};

    // Upper half of DSM word 0 once a run has completed
    // The host polls for this pattern to know the record is valid
    localparam logic [15:0] DSM_DONE_MARKER = 16'hc0de;

    // Copy engine states
    // IDLE waits for an enable, READ and WRITE each hold one bus cycle,
    // and DONE waits for the enable to drop
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        DONE
    } t_copy_state;

    // DSM writer states
    // PASS lends the bus to the engine, WORD0 and WORD1 write the record,
    // and HOLD keeps done high until the enable drops
    typedef enum logic [1:0] {
        PASS,
        WORD0,
        WORD1,
        HOLD
    } t_dsm_state;

endpackage

// File: verilog/qa_csr.sv
/* QA CSR decoder
   Turns host configuration writes into registered bases, word count and enable */

module qa_csr (
    input  logic                           clk,
    input  logic                           resetb,

    // Host write strobe, one write per cycle with no back-pressure
    input  logic                           cfg_valid,
    input  logic [qa_pkg::CFG_ADDR_W-1:0]  cfg_addr,
    input  logic [qa_pkg::DATA_W-1:0]      cfg_data,

    output logic [qa_pkg::ADDR_W-1:0]      dsm_base,
    output logic                           dsm_base_valid,
    output logic [qa_pkg::ADDR_W-1:0]      read_frame,
    output logic [qa_pkg::ADDR_W-1:0]      write_frame,
    output logic [qa_pkg::COUNT_W-1:0]     num_words,
    output logic                           afu_en
);

    logic [qa_pkg::CFG_ADDR_W+1:0] cfg_byte;

    logic hit_dsm_l;
    logic hit_dsm_h;
    logic hit_rd_l;
    logic hit_rd_h;
    logic hit_wr_l;
    logic hit_wr_h;
    logic hit_num;
    logic hit_en;

    // Addresses in the package are byte addresses
    assign cfg_byte = {cfg_addr, 2'b00};

    // One strobe per register
    // A write that matches none of them falls through and is ignored
    assign hit_dsm_l = cfg_valid && (cfg_byte == qa_pkg::CSR_AFU_DSM_BASEL);
    assign hit_dsm_h = cfg_valid && (cfg_byte == qa_pkg::CSR_AFU_DSM_BASEH);
    assign hit_rd_l  = cfg_valid && (cfg_byte == qa_pkg::CSR_AFU_READ_FRAME_BASEL);
    assign hit_rd_h  = cfg_valid && (cfg_byte == qa_pkg::CSR_AFU_READ_FRAME_BASEH);
    assign hit_wr_l  = cfg_valid && (cfg_byte == qa_pkg::CSR_AFU_WRITE_FRAME_BASEL);
    assign hit_wr_h  = cfg_valid && (cfg_byte == qa_pkg::CSR_AFU_WRITE_FRAME_BASEH);
    assign hit_num   = cfg_valid && (cfg_byte == qa_pkg::CSR_AFU_NUM_WORDS);
    assign hit_en    = cfg_valid && (cfg_byte == qa_pkg::CSR_AFU_EN);

    // DSM base, loaded in two 32-bit halves
    always_ff @(posedge clk) begin
        if (hit_dsm_l) begin
            dsm_base[31:0] <= cfg_data;
        end
        if (hit_dsm_h) begin
            dsm_base[63:32] <= cfg_data;
        end
    end

    // The low half counts as the valid write
    // The host is expected to set the high half first when it is non-zero
    always_ff @(posedge clk) begin
        if (!resetb) begin
            dsm_base_valid <= 1'b0;
        end else if (hit_dsm_l) begin
            dsm_base_valid <= 1'b1;
        end
    end

    // Source frame base
    always_ff @(posedge clk) begin
        if (hit_rd_l) begin
            read_frame[31:0] <= cfg_data;
        end
        if (hit_rd_h) begin
            read_frame[63:32] <= cfg_data;
        end
    end

    // Destination frame base
    always_ff @(posedge clk) begin
        if (hit_wr_l) begin
            write_frame[31:0] <= cfg_data;
        end
        if (hit_wr_h) begin
            write_frame[63:32] <= cfg_data;
        end
    end

    // Number of words to copy, only the low bits are kept
    always_ff @(posedge clk) begin
        if (hit_num) begin
            num_words <= cfg_data[qa_pkg::COUNT_W-1:0];
        end
    end

    // Enable takes bit 0 of the write
    // Writing 0 also re-arms the engine for the next run
    always_ff @(posedge clk) begin
        if (!resetb) begin
            afu_en <= 1'b0;
        end else if (hit_en) begin
            afu_en <= cfg_data[0];
        end
    end

endmodule

// File: verilog/qa_copy_engine.sv
/* QA copy engine
   Moves each word from the read frame to the write frame over Wishbone classic cycles */

module qa_copy_engine (
    input  logic                        clk,
    input  logic                        resetb,

    // Configuration from the CSR decoder
    input  logic                        dsm_base_valid,
    input  logic [qa_pkg::ADDR_W-1:0]   read_frame,
    input  logic [qa_pkg::ADDR_W-1:0]   write_frame,
    input  logic [qa_pkg::COUNT_W-1:0]  num_words,
    input  logic                        afu_en,

    // Bus request toward the DSM writer, which lends the master port
    input  logic                        eng_ack,
    input  logic [qa_pkg::DATA_W-1:0]   wb_dat_r,
    output logic                        eng_cyc,
    output logic                        eng_stb,
    output logic                        eng_we,
    output logic [qa_pkg::ADDR_W-1:0]   eng_adr,
    output logic [qa_pkg::DATA_W-1:0]   eng_dat_w,

    // Completion toward the DSM writer
    output logic                        copy_done,
    output logic [qa_pkg::COUNT_W-1:0]  copy_count,
    output logic [qa_pkg::DATA_W-1:0]   copy_sum,
    output logic                        afu_busy
);

    qa_pkg::t_copy_state state;

    logic                        req;
    logic                        rec_ack_seen;
    logic                        start;
    logic                        last_word;
    logic [qa_pkg::COUNT_W-1:0]  idx;
    logic [qa_pkg::COUNT_W-1:0]  words;
    logic [qa_pkg::DATA_W-1:0]   data_q;
    logic [qa_pkg::ADDR_W-1:0]   word_off;

    // A run needs an enable and a DSM base
    // DONE waits for the enable to drop, which allows only one run per enable
    assign start     = afu_en && dsm_base_valid;
    assign last_word = (idx == words - 1'b1);
    assign word_off  = {{(qa_pkg::ADDR_W - qa_pkg::COUNT_W){1'b0}}, idx};

    // Cycle and strobe always move together in this master
    assign eng_cyc   = req;
    assign eng_stb   = req;
    assign eng_we    = (state == qa_pkg::WRITE);

    // Address and data only change between cycles, so they are stable until ack
    assign eng_adr   = (state == qa_pkg::WRITE) ? write_frame + word_off
                                                : read_frame + word_off;
    assign eng_dat_w = data_q;

    // Control FSM
    // Every READ or WRITE spends one cycle with the request low before raising it,
    // which gives the idle cycle after each ack
    always_ff @(posedge clk) begin
        if (!resetb) begin
            state        <= qa_pkg::IDLE;
            req          <= 1'b0;
            rec_ack_seen <= 1'b0;
            copy_done    <= 1'b0;
            afu_busy     <= 1'b0;
        end else begin
            copy_done <= 1'b0;
            case (state)
                qa_pkg::IDLE: begin
                    if (start) begin
                        afu_busy     <= 1'b1;
                        rec_ack_seen <= 1'b0;
                        // An empty copy goes straight to the record
                        if (num_words == '0) begin
                            state     <= qa_pkg::DONE;
                            copy_done <= 1'b1;
                        end else begin
                            state <= qa_pkg::READ;
                        end
                    end
                end
                qa_pkg::READ: begin
                    if (!req) begin
                        req <= 1'b1;
                    end else if (eng_ack) begin
                        req   <= 1'b0;
                        state <= qa_pkg::WRITE;
                    end
                end
                qa_pkg::WRITE: begin
                    if (!req) begin
                        req <= 1'b1;
                    end else if (eng_ack) begin
                        req <= 1'b0;
                        if (last_word) begin
                            state     <= qa_pkg::DONE;
                            copy_done <= 1'b1;
                        end else begin
                            state <= qa_pkg::READ;
                        end
                    end
                end
                qa_pkg::DONE: begin
                    // The DSM writer keeps returning bus acks and the second one ends the record
                    if (eng_ack) begin
                        rec_ack_seen <= 1'b1;
                        if (rec_ack_seen) begin
                            afu_busy <= 1'b0;
                        end
                    end
                    if (!afu_en) begin
                        state    <= qa_pkg::IDLE;
                        afu_busy <= 1'b0;
                    end
                end
                default: state <= qa_pkg::IDLE;
            endcase
        end
    end

    // Datapath for the word index, the held word, the count and the checksum
    always_ff @(posedge clk) begin
        if (state == qa_pkg::IDLE && start) begin
            idx        <= '0;
            words      <= num_words;
            copy_count <= '0;
            copy_sum   <= '0;
        end
        if (state == qa_pkg::READ && req && eng_ack) begin
            data_q   <= wb_dat_r;
            copy_sum <= copy_sum + wb_dat_r;
        end
        if (state == qa_pkg::WRITE && req && eng_ack) begin
            copy_count <= copy_count + 1'b1;
            if (!last_word) begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

// File: verilog/qa_dsm_writer.sv
/* QA DSM record writer
   Lends the bus to the copy engine, then writes the two-word completion record */

module qa_dsm_writer (
    input  logic                        clk,
    input  logic                        resetb,
    input  logic                        afu_en,

    // Engine side of the bus
    input  logic                        eng_cyc,
    input  logic                        eng_stb,
    input  logic                        eng_we,
    input  logic [qa_pkg::ADDR_W-1:0]   eng_adr,
    input  logic [qa_pkg::DATA_W-1:0]   eng_dat_w,
    output logic                        eng_ack,

    // Completion from the engine
    input  logic                        copy_done,
    input  logic [qa_pkg::COUNT_W-1:0]  copy_count,
    input  logic [qa_pkg::DATA_W-1:0]   copy_sum,
    input  logic [qa_pkg::ADDR_W-1:0]   dsm_base,

    // Wishbone master port
    input  logic                        wb_ack,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output logic [qa_pkg::ADDR_W-1:0]   wb_adr,
    output logic [qa_pkg::DATA_W-1:0]   wb_dat_w,

    output logic                        afu_done
);

    qa_pkg::t_dsm_state state;

    logic                        req;
    logic                        pass;
    logic [qa_pkg::COUNT_W-1:0]  count_q;
    logic [qa_pkg::DATA_W-1:0]   sum_q;

    assign pass = (state == qa_pkg::PASS);

    // Acks go back to the engine in every state, it counts the record acks
    assign eng_ack  = wb_ack;

    // Outgoing bus mux between the engine and the record writes
    assign wb_cyc   = pass ? eng_cyc : req;
    assign wb_stb   = pass ? eng_stb : req;
    assign wb_we    = pass ? eng_we : 1'b1;
    assign wb_adr   = pass ? eng_adr
                    : (state == qa_pkg::WORD1) ? dsm_base + 1'b1 : dsm_base;
    assign wb_dat_w = pass ? eng_dat_w
                    : (state == qa_pkg::WORD1) ? sum_q
                    : {qa_pkg::DSM_DONE_MARKER, count_q};

    // Record FSM
    // WORD0 starts with the request already high, WORD1 waits one idle cycle first
    always_ff @(posedge clk) begin
        if (!resetb) begin
            state    <= qa_pkg::PASS;
            req      <= 1'b0;
            afu_done <= 1'b0;
        end else begin
            case (state)
                qa_pkg::PASS: begin
                    if (copy_done) begin
                        state <= qa_pkg::WORD0;
                        req   <= 1'b1;
                    end
                end
                qa_pkg::WORD0: begin
                    if (wb_ack) begin
                        req   <= 1'b0;
                        state <= qa_pkg::WORD1;
                    end
                end
                qa_pkg::WORD1: begin
                    if (!req) begin
                        req <= 1'b1;
                    end else if (wb_ack) begin
                        req      <= 1'b0;
                        afu_done <= 1'b1;
                        state    <= qa_pkg::HOLD;
                    end
                end
                qa_pkg::HOLD: begin
                    // Done stays up until the host clears the enable
                    if (!afu_en) begin
                        afu_done <= 1'b0;
                        state    <= qa_pkg::PASS;
                    end
                end
                default: state <= qa_pkg::PASS;
            endcase
        end
    end

    // Capture the run results when the engine finishes
    always_ff @(posedge clk) begin
        if (copy_done) begin
            count_q <= copy_count;
            sum_q   <= copy_sum;
        end
    end

endmodule

// File: verilog/qa_top.sv
/* QA accelerator top
   Wires the CSR decoder, copy engine and DSM writer to the host and Wishbone ports */

module qa_top (
    input  logic                           clk,
    input  logic                           resetb,

    // Host configuration writes
    input  logic                           cfg_valid,
    input  logic [qa_pkg::CFG_ADDR_W-1:0]  cfg_addr,
    input  logic [qa_pkg::DATA_W-1:0]      cfg_data,

    // Wishbone classic master
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic                           wb_we,
    output logic [qa_pkg::ADDR_W-1:0]      wb_adr,
    output logic [qa_pkg::DATA_W-1:0]      wb_dat_w,
    input  logic [qa_pkg::DATA_W-1:0]      wb_dat_r,
    input  logic                           wb_ack,

    output logic                           afu_busy,
    output logic                           afu_done
);

    // Configuration from the decoder
    logic [qa_pkg::ADDR_W-1:0]   dsm_base;
    logic                        dsm_base_valid;
    logic [qa_pkg::ADDR_W-1:0]   read_frame;
    logic [qa_pkg::ADDR_W-1:0]   write_frame;
    logic [qa_pkg::COUNT_W-1:0]  num_words;
    logic                        afu_en;

    // Engine bus request and completion
    logic                        eng_cyc;
    logic                        eng_stb;
    logic                        eng_we;
    logic [qa_pkg::ADDR_W-1:0]   eng_adr;
    logic [qa_pkg::DATA_W-1:0]   eng_dat_w;
    logic                        eng_ack;
    logic                        copy_done;
    logic [qa_pkg::COUNT_W-1:0]  copy_count;
    logic [qa_pkg::DATA_W-1:0]   copy_sum;

    qa_csr u_csr (
        .clk            (clk),
        .resetb         (resetb),
        .cfg_valid      (cfg_valid),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .dsm_base       (dsm_base),
        .dsm_base_valid (dsm_base_valid),
        .read_frame     (read_frame),
        .write_frame    (write_frame),
        .num_words      (num_words),
        .afu_en         (afu_en)
    );

    qa_copy_engine u_engine (
        .clk            (clk),
        .resetb         (resetb),
        .dsm_base_valid (dsm_base_valid),
        .read_frame     (read_frame),
        .write_frame    (write_frame),
        .num_words      (num_words),
        .afu_en         (afu_en),
        .eng_ack        (eng_ack),
        .wb_dat_r       (wb_dat_r),
        .eng_cyc        (eng_cyc),
        .eng_stb        (eng_stb),
        .eng_we         (eng_we),
        .eng_adr        (eng_adr),
        .eng_dat_w      (eng_dat_w),
        .copy_done      (copy_done),
        .copy_count     (copy_count),
        .copy_sum       (copy_sum),
        .afu_busy       (afu_busy)
    );

    // The DSM writer owns the outgoing bus
    qa_dsm_writer u_dsm (
        .clk            (clk),
        .resetb         (resetb),
        .afu_en         (afu_en),
        .eng_cyc        (eng_cyc),
        .eng_stb        (eng_stb),
        .eng_we         (eng_we),
        .eng_adr        (eng_adr),
        .eng_dat_w      (eng_dat_w),
        .eng_ack        (eng_ack),
        .copy_done      (copy_done),
        .copy_count     (copy_count),
        .copy_sum       (copy_sum),
        .dsm_base       (dsm_base),
        .wb_ack         (wb_ack),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .afu_done       (afu_done)
    );

endmodule

// File: verif/qa_mem_model.sv
/* Wishbone slave memory for the QA testbench
   Word-addressed, preloaded from an LCG, acks after 0 to 3 random wait states */

module qa_mem_model #(
    parameter logic [31:0] SEED = 32'd1
) (
    input  logic        clk,
    input  logic        resetb,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [63:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = 4096;

    // Live contents, and the untouched preload that the checks compare against
    logic [31:0] mem      [DEPTH];
    logic [31:0] init_mem [DEPTH];

    logic [31:0] wait_lcg;
    logic [1:0]  wait_left;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Every word mixes the LCG stream with its own address
    initial begin
        logic [31:0] s;
        s = SEED;
        for (int i = 0; i < DEPTH; i++) begin
            s = lcg_next(s);
            init_mem[i] = s ^ i;
            mem[i] = init_mem[i];
        end
    end

    // Ack is registered and drops right after one cycle, as classic cycles need
    always @(posedge clk) begin
        if (!resetb) begin
            wb_ack    <= 1'b0;
            wait_lcg  <= SEED;
            wait_left <= 2'd0;
        end else if (wb_ack) begin
            wb_ack    <= 1'b0;
            wait_lcg  <= lcg_next(wait_lcg);
            wait_left <= wait_lcg[31:30];
        end else if (wb_cyc && wb_stb) begin
            if (wait_left == 2'd0) begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    mem[wb_adr[11:0]] <= wb_dat_w;
                end else begin
                    wb_dat_r <= mem[wb_adr[11:0]];
                end
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

// File: verif/qa_tb.sv
/* QA accelerator testbench
   Runs a table of copy jobs through the DUT and checks the copied words and the DSM record */

module qa_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 5;
    localparam int HOLD_CYCLES = 20;

    // One copy job per row
    typedef struct {
        logic [63:0] rd;
        logic [63:0] wr;
        int          nw;
        logic [63:0] dsm;
        logic [11:0] stray;
        bit          dsm_first;
    } row_t;

    logic        clk;
    logic        resetb;
    logic        cfg_valid;
    logic [11:0] cfg_addr;
    logic [31:0] cfg_data;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [63:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        afu_busy;
    logic        afu_done;

    row_t rows [NUM_ROWS];
    int   errors;
    int   rows_passed;
    int   rows_failed;
    int   cycles;
    int   cycle_limit;
    bit   quiet;

    qa_top u_dut (
        .clk       (clk),
        .resetb    (resetb),
        .cfg_valid (cfg_valid),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .afu_busy  (afu_busy),
        .afu_done  (afu_done)
    );

    qa_mem_model #(.SEED(32'd29909)) u_mem (
        .clk      (clk),
        .resetb   (resetb),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Global limit on run length
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // While the engine must be idle, no bus cycle and no busy or done may show
    always @(negedge clk) begin
        if (quiet) begin
            assert (!wb_cyc && !afu_busy && !afu_done) else begin
                $display("activity while idle: wb_cyc=%b afu_busy=%b afu_done=%b",
                         wb_cyc, afu_busy, afu_done);
                errors++;
            end
        end
    end

    // A classic master raises and drops cycle and strobe together
    always @(negedge clk) begin
        if (resetb) begin
            assert (wb_stb === wb_cyc) else begin
                $display("wb_stb and wb_cyc differ: wb_cyc=%b wb_stb=%b", wb_cyc, wb_stb);
                errors++;
            end
        end
    end

    // Worst-case cycles to afu_done with 5 clocks allowed per bus cycle
    function automatic int row_bound(input int nw);
        return (2 * nw + 2) * 5 + 40;
    endfunction

    // The first row has no DSM base yet, so it checks the start gate
    task automatic load_table();
        rows[0] = '{64'h100, 64'h800, 8,  64'hf00, 12'h68a, 1'b0};
        rows[1] = '{64'h140, 64'h840, 5,  64'hf10, 12'h683, 1'b1};
        rows[2] = '{64'h180, 64'h880, 12, 64'hf20, 12'h000, 1'b1};
        rows[3] = '{64'h1c0, 64'h8c0, 0,  64'hf30, 12'h6ff, 1'b1};
        rows[4] = '{64'h200, 64'h900, 3,  64'hf40, 12'h682, 1'b1};
    endtask

    // One host write, held for a single cycle
    task automatic csr_write(input logic [13:0] byte_addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        cfg_valid = 1'b1;
        cfg_addr  = byte_addr[13:2];
        cfg_data  = data;
        @(posedge clk);
        #2;
        cfg_valid = 1'b0;
    endtask

    task automatic check_value(input string name, input int unsigned addr,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s at word 0x%h: got 0x%h, expected 0x%h",
                     name, addr, got, exp);
            errors++;
        end
    endtask

    task automatic wait_done(input int bound, output bit seen);
        seen = 1'b0;
        for (int i = 0; i < bound; i++) begin
            @(negedge clk);
            if (afu_done) begin
                seen = 1'b1;
                break;
            end
            // The engine starts one clock after the last CSR write lands
            if (i > 0) begin
                assert (afu_busy) else begin
                    $display("afu_busy low while the run was still in progress");
                    errors++;
                end
            end
        end
        assert (seen) else begin
            $display("afu_done did not rise within %0d cycles", bound);
            errors++;
        end
        assert (!seen || !afu_busy) else begin
            $display("afu_busy still high after afu_done rose");
            errors++;
        end
    endtask

    // After a run the enable stays high, and the engine must not start again
    task automatic watch_no_cycle(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!wb_cyc) else begin
                $display("bus cycle started after afu_done while afu_en stayed high");
                errors++;
            end
        end
    endtask

    task automatic run_row(input int r);
        int          bound;
        int          errors_before;
        int unsigned src;
        int unsigned dst;
        int unsigned dsm;
        logic [31:0] sum;
        bit          seen;
        errors_before = errors;
        bound = row_bound(rows[r].nw);
        quiet = 1'b1;
        csr_write(qa_pkg::CSR_AFU_READ_FRAME_BASEH, rows[r].rd[63:32]);
        csr_write(qa_pkg::CSR_AFU_READ_FRAME_BASEL, rows[r].rd[31:0]);
        csr_write(qa_pkg::CSR_AFU_WRITE_FRAME_BASEH, rows[r].wr[63:32]);
        csr_write(qa_pkg::CSR_AFU_WRITE_FRAME_BASEL, rows[r].wr[31:0]);
        csr_write(qa_pkg::CSR_AFU_NUM_WORDS, 32'(rows[r].nw));
        // All ones would corrupt whatever register the stray address aliased
        csr_write({rows[r].stray, 2'b00}, 32'hffff_ffff);
        if (rows[r].dsm_first) begin
            csr_write(qa_pkg::CSR_AFU_DSM_BASEH, rows[r].dsm[63:32]);
            csr_write(qa_pkg::CSR_AFU_DSM_BASEL, rows[r].dsm[31:0]);
            csr_write(qa_pkg::CSR_AFU_EN, 32'd1);
            quiet = 1'b0;
        end else begin
            // The idle monitor keeps watching while the enable is set without a DSM base
            csr_write(qa_pkg::CSR_AFU_EN, 32'd1);
            repeat (bound) @(negedge clk);
            quiet = 1'b0;
            csr_write(qa_pkg::CSR_AFU_DSM_BASEH, rows[r].dsm[63:32]);
            csr_write(qa_pkg::CSR_AFU_DSM_BASEL, rows[r].dsm[31:0]);
        end
        wait_done(bound, seen);
        if (seen) begin
            sum = 32'd0;
            for (int i = 0; i < rows[r].nw; i++) begin
                src = int'(rows[r].rd[11:0]) + i;
                dst = int'(rows[r].wr[11:0]) + i;
                sum = sum + u_mem.init_mem[src[11:0]];
                check_value("dst_word", dst, u_mem.mem[dst[11:0]], u_mem.init_mem[src[11:0]]);
            end
            // Record is the marker with the count, then the modulo sum
            dsm = int'(rows[r].dsm[11:0]);
            check_value("dsm_word0", dsm, u_mem.mem[dsm[11:0]],
                        {qa_pkg::DSM_DONE_MARKER, 16'(rows[r].nw)});
            dsm = dsm + 1;
            check_value("dsm_word1", dsm, u_mem.mem[dsm[11:0]], sum);
            watch_no_cycle(HOLD_CYCLES);
        end
        csr_write(qa_pkg::CSR_AFU_EN, 32'd0);
        repeat (2) @(negedge clk);
        assert (!afu_done) else begin
            $display("afu_done still high after afu_en was cleared");
            errors++;
        end
        if (errors == errors_before) begin
            rows_passed++;
        end else begin
            rows_failed++;
        end
        $display("row %0d: %0d words 0x%h -> 0x%h, dsm 0x%h, %0d errors", r, rows[r].nw,
                 rows[r].rd, rows[r].wr, rows[r].dsm, errors - errors_before);
    endtask

    initial begin
        resetb      = 1'b0;
        cfg_valid   = 1'b0;
        cfg_addr    = '0;
        cfg_data    = '0;
        quiet       = 1'b0;
        errors      = 0;
        rows_passed = 0;
        rows_failed = 0;
        cycles      = 0;
        load_table();
        // Each row gets its wait bound twice, plus room for CSR writes and the hold
        cycle_limit = 40;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += 2 * row_bound(rows[r].nw) + 40 + HOLD_CYCLES;
        end

        repeat (10) @(posedge clk);
        #2;
        resetb = 1'b1;
        quiet = 1'b1;
        repeat (2) @(negedge clk);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        quiet = 1'b0;

        $display("rows passed %0d, rows failed %0d, errors %0d",
                 rows_passed, rows_failed, errors);
        if (errors == 0 && rows_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/qa_pkg.sv
verilog/qa_csr.sv
verilog/qa_copy_engine.sv
verilog/qa_dsm_writer.sv
verilog/qa_top.sv
verif/qa_mem_model.sv
verif/qa_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the QA accelerator testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module qa_tb \
    --Mdir obj_dir \
    -f flist.f

output="$(./obj_dir/Vqa_tb)"
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi
